// ==== all.f ====
source/alu_data_pkg.sv
source/alu_op_pkg.sv
source/alu_operands_if.sv
source/alu_adder_cmp.sv
source/alu_shifter.sv
source/alu_polar_simd.sv
source/alu_result_stage.sv
source/alu_top.sv
testbench/tb_alu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ALU testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_alu_top -f all.f -o sim_alu &&
    ./obj_dir/sim_alu ||
    { echo "ALU simulation failed"; exit 1; }
echo "ALU simulation done"

// ==== testbench/tb_alu_top.sv ====
/*
 * ALU testbench
 * Random operations against a reference model, one-cycle latency check
 */
`timescale 1ns/1ps

module tb_alu_top;

    localparam int N_OPS          = 2000;
    localparam int RESET_CYCLES   = 4;
    // About one idle cycle in five, so half the op count is ample margin
    localparam int TIMEOUT_CYCLES = N_OPS + N_OPS / 2;

    typedef struct packed {
        logic        taken;
        logic [63:0] result;
    } expect_t;

    logic                clk_i = 1'b0;
    logic                rst_n_i;
    logic                valid_i;
    alu_op_pkg::alu_op_e op_i;
    logic [63:0]         operand_a_i;
    logic [63:0]         operand_b_i;
    logic [63:0]         imm_i;
    logic                valid_o;
    logic [63:0]         result_o;
    logic                branch_taken_o;

    expect_t exp_q[$];
    int      cycle_count;

    alu_top DUT (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .imm_i          (imm_i),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .branch_taken_o (branch_taken_o)
    );

    always #5 clk_i = ~clk_i;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [7:0] polar_lane(alu_op_pkg::alu_op_e op, logic [7:0] la,
                                              logic [7:0] lb, logic [7:0] li, logic [7:0] b0);
        int ia;
        int ib;
        int ma;
        int mb;
        int m;
        int g;
        ia = $signed(la);
        ib = $signed(lb);
        ma = (ia < 0) ? -ia : ia;
        mb = (ib < 0) ? -ib : ib;
        case (op)
            alu_op_pkg::PL_R:      return (b0 == 8'd1) ? 8'd0 : ((ia < 0) ? 8'd1 : 8'd0);
            alu_op_pkg::PL_F: begin
                m = (ma > mb) ? mb : ma;
                if ((ia < 0) != (ib < 0)) m = -m;
                return 8'(m);
            end
            alu_op_pkg::PL_DECODE: return (b0 == 8'd0) ? la : 8'd0;
            alu_op_pkg::PL_EVAL:   return (ia == 1) ? 8'hFF : 8'h00;
            alu_op_pkg::PL_G: begin
                g = (li == 8'd0) ? ia + ib : ib - ia;
                if (g > 127) g = 127;
                else if (g < -127) g = -127;
                return 8'(g);
            end
            default:               return 8'd0;
        endcase
    endfunction

    function automatic expect_t alu_model(alu_op_pkg::alu_op_e op, logic [63:0] a,
                                          logic [63:0] b, logic [63:0] imm);
        expect_t     e;
        logic [31:0] w;
        e.taken  = 1'b1;
        e.result = '0;
        w        = '0;
        case (op)
            alu_op_pkg::ADD:  e.result = a + b;
            alu_op_pkg::SUB:  e.result = a - b;
            alu_op_pkg::ADDW: w = a[31:0] + b[31:0];
            alu_op_pkg::SUBW: w = a[31:0] - b[31:0];
            alu_op_pkg::ANDL: e.result = a & b;
            alu_op_pkg::ORL:  e.result = a | b;
            alu_op_pkg::XORL: e.result = a ^ b;
            alu_op_pkg::SLL:  e.result = a << b[5:0];
            alu_op_pkg::SRL:  e.result = a >> b[5:0];
            alu_op_pkg::SRA:  e.result = $signed(a) >>> b[5:0];
            alu_op_pkg::SLLW: w = a[31:0] << b[4:0];
            alu_op_pkg::SRLW: w = a[31:0] >> b[4:0];
            alu_op_pkg::SRAW: w = $signed(a[31:0]) >>> b[4:0];
            alu_op_pkg::SLTS: e.result = {63'd0, $signed(a) < $signed(b)};
            alu_op_pkg::SLTU: e.result = {63'd0, a < b};
            alu_op_pkg::EQ:   e.taken = (a == b);
            alu_op_pkg::NE:   e.taken = (a != b);
            alu_op_pkg::LTS:  e.taken = ($signed(a) < $signed(b));
            alu_op_pkg::LTU:  e.taken = (a < b);
            alu_op_pkg::GES:  e.taken = ($signed(a) >= $signed(b));
            alu_op_pkg::GEU:  e.taken = (a >= b);
            default: begin
                for (int i = 0; i < 8; i++) begin
                    e.result[8*i +: 8] = polar_lane(op, a[8*i +: 8], b[8*i +: 8],
                                                    imm[8*i +: 8], b[7:0]);
                end
            end
        endcase
        // Word forms come back sign extended from bit 31
        case (op)
            alu_op_pkg::ADDW, alu_op_pkg::SUBW, alu_op_pkg::SLLW,
            alu_op_pkg::SRLW, alu_op_pkg::SRAW: e.result = {{32{w[31]}}, w};
            default: ;
        endcase
        return e;
    endfunction

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [63:0] random_word();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            2:       return 64'h8000_0000_0000_0000;
            3:       return 64'h7FFF_FFFF_FFFF_FFFF;
            default: return {$urandom(), $urandom()};
        endcase
    endfunction

    // Lanes biased toward saturation and compare corners
    function automatic logic [63:0] random_lanes(bit allow_zero_bias);
        logic [63:0] v;
        for (int i = 0; i < 8; i++) begin
            case ($urandom_range(0, 6))
                0:       v[8*i +: 8] = 8'h7F;
                1:       v[8*i +: 8] = 8'h81;
                2:       v[8*i +: 8] = 8'h80;
                3:       v[8*i +: 8] = 8'h01;
                default: v[8*i +: 8] = 8'($urandom());
            endcase
            if (allow_zero_bias && $urandom_range(0, 1) == 0) v[8*i +: 8] = 8'h00;
        end
        return v;
    endfunction

    task automatic make_operation(output alu_op_pkg::alu_op_e op, output logic [63:0] a,
                                  output logic [63:0] b, output logic [63:0] imm);
        op  = alu_op_pkg::alu_op_e'($urandom_range(0, 25));
        a   = random_word();
        b   = random_word();
        imm = random_word();
        if (op >= alu_op_pkg::EQ && op <= alu_op_pkg::GEU && $urandom_range(0, 3) == 0) begin
            b = a;
        end
        if (op >= alu_op_pkg::PL_R) begin
            a   = random_lanes(1'b0);
            b   = random_lanes(1'b0);
            imm = random_lanes(1'b1);
            if ((op == alu_op_pkg::PL_R || op == alu_op_pkg::PL_DECODE) &&
                $urandom_range(0, 3) != 0) begin
                b[7:0] = 8'($urandom_range(0, 1));
            end
        end
    endtask

    task automatic check_value(logic [63:0] actual, logic [63:0] expected, string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        alu_op_pkg::alu_op_e op;
        logic [63:0]         a;
        logic [63:0]         b;
        logic [63:0]         imm;
        int                  sent;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        op_i        = alu_op_pkg::ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        imm_i       = '0;
        sent        = 0;
        void'($urandom(38));
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value(valid_o, 0, "valid_o after reset");
        check_value(result_o, 0, "result_o after reset");
        check_value(branch_taken_o, 0, "branch_taken_o after reset");
        while (sent < N_OPS) begin
            @(posedge clk_i);
            if ($urandom_range(0, 4) == 0) begin
                valid_i <= 1'b0;
            end else begin
                make_operation(op, a, b, imm);
                valid_i     <= 1'b1;
                op_i        <= op;
                operand_a_i <= a;
                operand_b_i <= b;
                imm_i       <= imm;
                exp_q.push_back(alu_model(op, a, b, imm));
                sent++;
            end
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);
        $display("Simulation finished: PASS");
        $finish;
    end

    // --------------------------------------------------
    // Response checking
    // --------------------------------------------------
    initial begin
        expect_t     exp;
        logic        valid_d;
        logic [63:0] last_result;
        logic        last_taken;
        valid_d     = 1'b0;
        last_result = '0;
        last_taken  = 1'b0;
        @(posedge rst_n_i);
        forever begin
            @(negedge clk_i);
            check_value(valid_o, valid_d, "valid_o");
            if (valid_o) begin
                exp = exp_q.pop_front();
                check_value(result_o, exp.result, "result_o");
                check_value(branch_taken_o, exp.taken, "branch_taken_o");
                last_result = result_o;
                last_taken  = branch_taken_o;
            end else begin
                // Idle cycle keeps the previous outputs
                check_value(result_o, last_result, "held result_o");
                check_value(branch_taken_o, last_taken, "held branch_taken_o");
            end
            valid_d = valid_i;
        end
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// ==== source/alu_top.sv ====
/*
 * ALU top level
 * Registered single-cycle integer and polar SIMD execution unit
 */
`timescale 1ns/1ps

module alu_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  alu_op_pkg::alu_op_e   op_i,
    input  alu_data_pkg::xlen_t   operand_a_i,
    input  alu_data_pkg::xlen_t   operand_b_i,
    input  alu_data_pkg::xlen_t   imm_i,
    output logic                  valid_o,
    output alu_data_pkg::xlen_t   result_o,
    output logic                  branch_taken_o
);

    alu_data_pkg::xlen_t sum;
    alu_data_pkg::xlen_t shift;
    alu_data_pkg::xlen_t polar;
    logic                less;
    logic                branch_taken;

    alu_operands_if opnd_if ();

    assign opnd_if.op             = op_i;
    assign opnd_if.operand_a.word = operand_a_i;
    assign opnd_if.operand_b.word = operand_b_i;
    assign opnd_if.imm.word       = imm_i;

    // Combinational units
    alu_adder_cmp u_adder_cmp (
        .opnd_if        (opnd_if),
        .sum_o          (sum),
        .less_o         (less),
        .branch_taken_o (branch_taken)
    );

    alu_shifter u_shifter (
        .opnd_if (opnd_if),
        .shift_o (shift)
    );

    alu_polar_simd u_polar_simd (
        .opnd_if (opnd_if),
        .polar_o (polar)
    );

    alu_result_stage u_result_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .opnd_if        (opnd_if),
        .sum_i          (sum),
        .less_i         (less),
        .branch_taken_i (branch_taken),
        .shift_i        (shift),
        .polar_i        (polar),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .branch_taken_o (branch_taken_o)
    );

endmodule

// ==== source/alu_result_stage.sv ====
/*
 * ALU result stage
 * Bitwise logic, final result mux and the single output register
 */
`timescale 1ns/1ps

module alu_result_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    alu_operands_if.sink          opnd_if,
    input  alu_data_pkg::xlen_t   sum_i,
    input  logic                  less_i,
    input  logic                  branch_taken_i,
    input  alu_data_pkg::xlen_t   shift_i,
    input  alu_data_pkg::xlen_t   polar_i,
    output logic                  valid_o,
    output alu_data_pkg::xlen_t   result_o,
    output logic                  branch_taken_o
);

    alu_data_pkg::xlen_t a_word;
    alu_data_pkg::xlen_t b_word;
    alu_data_pkg::xlen_t result_d;

    assign a_word = opnd_if.operand_a.word;
    assign b_word = opnd_if.operand_b.word;

    // --------------------------------------------------
    // Result mux
    // --------------------------------------------------
    always_comb begin
        case (opnd_if.op)
            alu_op_pkg::ANDL:      result_d = a_word & b_word;
            alu_op_pkg::ORL:       result_d = a_word | b_word;
            alu_op_pkg::XORL:      result_d = a_word ^ b_word;
            alu_op_pkg::ADD,
            alu_op_pkg::SUB,
            alu_op_pkg::ADDW,
            alu_op_pkg::SUBW:      result_d = sum_i;
            alu_op_pkg::SLL,
            alu_op_pkg::SRL,
            alu_op_pkg::SRA,
            alu_op_pkg::SLLW,
            alu_op_pkg::SRLW,
            alu_op_pkg::SRAW:      result_d = shift_i;
            alu_op_pkg::SLTS,
            alu_op_pkg::SLTU:      result_d = {{(alu_data_pkg::XLEN - 1){1'b0}}, less_i};
            alu_op_pkg::PL_R,
            alu_op_pkg::PL_F,
            alu_op_pkg::PL_DECODE,
            alu_op_pkg::PL_EVAL,
            alu_op_pkg::PL_G:      result_d = polar_i;
            // Branches only produce the taken bit
            default:               result_d = '0;
        endcase
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o        <= 1'b0;
            result_o       <= '0;
            branch_taken_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // Hold last result across idle cycles
            if (valid_i) begin
                result_o       <= result_d;
                branch_taken_o <= branch_taken_i;
            end
        end
    end

endmodule

// ==== source/alu_polar_simd.sv ====
/*
 * Polar decoder SIMD unit
 * Eight signed 8-bit lanes, saturating g kernel
 */
`timescale 1ns/1ps

module alu_polar_simd (
    alu_operands_if.sink          opnd_if,
    output alu_data_pkg::xlen_t   polar_o
);

    alu_data_pkg::operand_u r_res;
    alu_data_pkg::operand_u f_res;
    alu_data_pkg::operand_u dec_res;
    alu_data_pkg::operand_u eval_res;
    alu_data_pkg::operand_u g_res;
    alu_data_pkg::lane_t    b_lane0;

    // Lane 0 of B acts as a control value for PL_R and PL_DECODE
    assign b_lane0 = opnd_if.operand_b.lane[0];

    // --------------------------------------------------
    // Per-lane kernels
    // --------------------------------------------------
    always_comb begin
        alu_data_pkg::lane_t                 a;
        alu_data_pkg::lane_t                 b;
        logic [alu_data_pkg::LANE_W-1:0]     abs_a;
        logic [alu_data_pkg::LANE_W-1:0]     abs_b;
        logic [alu_data_pkg::LANE_W-1:0]     mag;
        logic                                neg;
        logic signed [alu_data_pkg::LANE_W:0] sum9;
        logic signed [alu_data_pkg::LANE_W:0] diff9;
        logic signed [alu_data_pkg::LANE_W:0] g9;

        for (int i = 0; i < alu_data_pkg::N_LANES; i++) begin
            a = opnd_if.operand_a.lane[i];
            b = opnd_if.operand_b.lane[i];

            // Hard decision
            r_res.lane[i] = (b_lane0 == 8'sd1) ? 8'sd0 : (a[alu_data_pkg::LANE_W-1] ? 8'sd1 : 8'sd0);

            // f: min magnitude with the product sign; -128 maps to 128
            abs_a = a[alu_data_pkg::LANE_W-1] ? -a : a;
            abs_b = b[alu_data_pkg::LANE_W-1] ? -b : b;
            neg   = a[alu_data_pkg::LANE_W-1] ^ b[alu_data_pkg::LANE_W-1];
            mag   = (abs_a > abs_b) ? abs_b : abs_a;
            f_res.lane[i] = neg ? -mag : mag;

            dec_res.lane[i]  = (b_lane0 == 8'sd0) ? a : 8'sd0;
            eval_res.lane[i] = (a == 8'sd1) ? 8'hFF : 8'h00;

            // g: 9-bit sum or difference, clamped to +/-127
            sum9  = a + b;
            diff9 = b - a;
            g9    = (opnd_if.imm.lane[i] == 8'sd0) ? sum9 : diff9;
            if (g9 > 9'sd127) begin
                g_res.lane[i] = 8'sd127;
            end else if (g9 < -9'sd127) begin
                g_res.lane[i] = -8'sd127;
            end else begin
                g_res.lane[i] = g9[alu_data_pkg::LANE_W-1:0];
            end
        end
    end

    // --------------------------------------------------
    // Kernel select
    // --------------------------------------------------
    always_comb begin
        case (opnd_if.op)
            alu_op_pkg::PL_R:      polar_o = r_res.word;
            alu_op_pkg::PL_F:      polar_o = f_res.word;
            alu_op_pkg::PL_DECODE: polar_o = dec_res.word;
            alu_op_pkg::PL_EVAL:   polar_o = eval_res.word;
            alu_op_pkg::PL_G:      polar_o = g_res.word;
            default:               polar_o = '0;
        endcase
    end

endmodule

// ==== source/alu_shifter.sv ====
/*
 * ALU shifter
 * 64-bit and word shifts on a single arithmetic right-shift path
 */
`timescale 1ns/1ps

module alu_shifter (
    alu_operands_if.sink          opnd_if,
    output alu_data_pkg::xlen_t   shift_o
);

    logic                             shift_left;
    logic                             shift_arith;
    logic                             shift_word;
    alu_data_pkg::xlen_t              a_word;
    alu_data_pkg::xlen_t              a_rev64;
    logic [alu_data_pkg::WLEN-1:0]    a_rev32;
    alu_data_pkg::xlen_t              shift_in64;
    logic [alu_data_pkg::WLEN-1:0]    shift_in32;
    logic [alu_data_pkg::XLEN:0]      right64;
    logic [alu_data_pkg::WLEN:0]      right32;
    alu_data_pkg::xlen_t              left64;
    logic [alu_data_pkg::WLEN-1:0]    left32;
    alu_data_pkg::xlen_t              res64;
    logic [alu_data_pkg::WLEN-1:0]    res32;

    assign a_word      = opnd_if.operand_a.word;
    assign shift_left  = (opnd_if.op == alu_op_pkg::SLL) || (opnd_if.op == alu_op_pkg::SLLW);
    assign shift_arith = (opnd_if.op == alu_op_pkg::SRA) || (opnd_if.op == alu_op_pkg::SRAW);
    assign shift_word  = (opnd_if.op == alu_op_pkg::SLLW) ||
                         (opnd_if.op == alu_op_pkg::SRLW) ||
                         (opnd_if.op == alu_op_pkg::SRAW);

    // Left shift = reverse, shift right, reverse back
    assign a_rev64 = {<<{a_word}};
    assign a_rev32 = {<<{a_word[alu_data_pkg::WLEN-1:0]}};

    assign shift_in64 = shift_left ? a_rev64 : a_word;
    assign shift_in32 = shift_left ? a_rev32 : a_word[alu_data_pkg::WLEN-1:0];

    // Top bit only carries the sign for arithmetic shifts
    assign right64 = $signed({shift_arith & shift_in64[alu_data_pkg::XLEN-1], shift_in64})
                     >>> opnd_if.operand_b.word[5:0];
    assign right32 = $signed({shift_arith & shift_in32[alu_data_pkg::WLEN-1], shift_in32})
                     >>> opnd_if.operand_b.word[4:0];

    assign left64 = {<<{right64[alu_data_pkg::XLEN-1:0]}};
    assign left32 = {<<{right32[alu_data_pkg::WLEN-1:0]}};

    assign res64 = shift_left ? left64 : right64[alu_data_pkg::XLEN-1:0];
    assign res32 = shift_left ? left32 : right32[alu_data_pkg::WLEN-1:0];

    assign shift_o = shift_word ?
                     {{(alu_data_pkg::XLEN - alu_data_pkg::WLEN){res32[alu_data_pkg::WLEN-1]}},
                      res32} :
                     res64;

endmodule

// ==== source/alu_adder_cmp.sv ====
/*
 * ALU adder and comparator
 * Shared add/subtract, magnitude compare and branch resolution
 */
`timescale 1ns/1ps

module alu_adder_cmp (
    alu_operands_if.sink          opnd_if,
    output alu_data_pkg::xlen_t   sum_o,
    output logic                  less_o,
    output logic                  branch_taken_o
);

    logic                         negate_b;
    logic                         signed_cmp;
    logic                         zero_flag;
    logic [alu_data_pkg::XLEN:0]  adder_a;
    logic [alu_data_pkg::XLEN:0]  adder_b;
    logic [alu_data_pkg::XLEN:0]  adder_ext;
    alu_data_pkg::xlen_t          adder_res;
    alu_data_pkg::xlen_t          a_word;
    alu_data_pkg::xlen_t          b_word;

    assign a_word = opnd_if.operand_a.word;
    assign b_word = opnd_if.operand_b.word;

    // --------------------------------------------------
    // Adder
    // --------------------------------------------------
    always_comb begin
        case (opnd_if.op)
            alu_op_pkg::SUB,
            alu_op_pkg::SUBW,
            alu_op_pkg::EQ,
            alu_op_pkg::NE:  negate_b = 1'b1;
            default:         negate_b = 1'b0;
        endcase
    end

    // Extra LSB carries the +1 of the two's complement
    assign adder_a   = {a_word, 1'b1};
    assign adder_b   = {b_word, 1'b0} ^ {(alu_data_pkg::XLEN + 1){negate_b}};
    assign adder_ext = adder_a + adder_b;
    assign adder_res = adder_ext[alu_data_pkg::XLEN:1];
    assign zero_flag = ~|adder_res;

    // Word forms keep the low half, sign extended
    assign sum_o = (opnd_if.op == alu_op_pkg::ADDW || opnd_if.op == alu_op_pkg::SUBW) ?
                   {{(alu_data_pkg::XLEN - alu_data_pkg::WLEN){adder_res[alu_data_pkg::WLEN-1]}},
                    adder_res[alu_data_pkg::WLEN-1:0]} :
                   adder_res;

    // --------------------------------------------------
    // Compare and branch
    // --------------------------------------------------
    assign signed_cmp = (opnd_if.op == alu_op_pkg::SLTS) ||
                        (opnd_if.op == alu_op_pkg::LTS)  ||
                        (opnd_if.op == alu_op_pkg::GES);

    assign less_o = $signed({signed_cmp & a_word[alu_data_pkg::XLEN-1], a_word}) <
                    $signed({signed_cmp & b_word[alu_data_pkg::XLEN-1], b_word});

    always_comb begin
        case (opnd_if.op)
            alu_op_pkg::EQ:  branch_taken_o = zero_flag;
            alu_op_pkg::NE:  branch_taken_o = ~zero_flag;
            alu_op_pkg::LTS,
            alu_op_pkg::LTU: branch_taken_o = less_o;
            alu_op_pkg::GES,
            alu_op_pkg::GEU: branch_taken_o = ~less_o;
            default:         branch_taken_o = 1'b1;
        endcase
    end

endmodule

// ==== source/alu_operands_if.sv ====
/*
 * ALU operand bundle
 * Operator, both operands and the immediate
 */
`timescale 1ns/1ps

interface alu_operands_if;

    alu_op_pkg::alu_op_e    op;
    alu_data_pkg::operand_u operand_a;
    alu_data_pkg::operand_u operand_b;
    alu_data_pkg::operand_u imm;

    modport source (output op, output operand_a, output operand_b, output imm);
    modport sink   (input op, input operand_a, input operand_b, input imm);

endinterface

// ==== source/alu_op_pkg.sv ====
/*
 * ALU operator encoding
 * Base integer, branch and polar SIMD operators
 */
package alu_op_pkg;

    typedef enum logic [4:0] {
        // Arithmetic
        ADD,
        SUB,
        ADDW,
        SUBW,
        // Bitwise logic
        ANDL,
        ORL,
        XORL,
        // Shifts
        SLL,
        SRL,
        SRA,
        SLLW,
        SRLW,
        SRAW,
        // Set less than
        SLTS,
        SLTU,
        // Branch conditions
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // Polar decoder kernels
        PL_R,
        PL_F,
        PL_DECODE,
        PL_EVAL,
        PL_G
    } alu_op_e;

endpackage

// ==== source/alu_data_pkg.sv ====
/*
 * ALU data definitions
 * Word width, polar lane geometry and the shared operand word
 */
package alu_data_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    parameter int XLEN    = 64;
    parameter int WLEN    = 32;
    parameter int LANE_W  = 8;
    parameter int N_LANES = XLEN / LANE_W;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [XLEN-1:0] xlen_t;

    // Signed polar lane
    typedef logic signed [LANE_W-1:0] lane_t;

    // One operand word, seen as a scalar or as eight lanes
    // Lane 0 sits in the least significant byte
    typedef union packed {
        xlen_t                     word;
        lane_t [N_LANES-1:0]       lane;
    } operand_u;

endpackage
